/* rtl/spi_pkg.sv */
// Register map, reset values and sizes shared by the SPI master blocks
// FIFO depths must be powers of two; credit width covers the full depth
package spi_pkg;

  localparam int N_SLAVES = 1;
  localparam int N_GPIO   = 8;

  localparam logic [31:0] BASE_ADDR    = 32'hB000_0000;
  localparam logic [31:0] VERSION_WORD = 32'h0001_0000;  // Major 1, minor 0

  localparam int TX_DEPTH = 4;
  localparam int RX_DEPTH = 4;
  localparam int CRED_W   = $clog2(TX_DEPTH) + 1;

  localparam int GAP_CYCLES = 6;  // Idle clk cycles between bytes
  localparam int GAP_W      = $clog2(GAP_CYCLES);

  // Config word: cpol[0], cpha[1], divider[5:2], slave select above
  localparam int CFG_DIV_LSB = 2;
  localparam int CFG_SS_LSB  = 6;
  localparam int CFG_W       = CFG_SS_LSB + N_SLAVES;
  localparam logic [CFG_W-1:0] CFG_RESET = CFG_W'(9 << CFG_DIV_LSB);

  typedef enum logic [2:0] {
    REG_CFG     = 3'd0,
    REG_GPIO    = 3'd1,
    REG_VERSION = 3'd2,
    REG_TX      = 3'd3,
    REG_RX      = 3'd4
  } spi_reg_e;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    GAP
  } spi_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } spi_resp_e;

endpackage

/* rtl/spi_byte_fifo.sv */
// Byte FIFO, DEPTH a power of two and at least 2
// No full flag, the producer must never push more than DEPTH entries ahead
`timescale 1ns/1ps
module spi_byte_fifo #(
  parameter int DEPTH = 4
) (
  input  logic       clk_i,
  input  logic       arst_i,
  input  logic       push_i,
  input  logic [7:0] data_i,
  input  logic       pop_i,
  output logic [7:0] data_o,
  output logic       empty_o
);
  localparam int AW = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW:0] wr_ptr_q;  // Extra bit tells wrap laps apart
  logic [AW:0] rd_ptr_q;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign data_o  = mem[rd_ptr_q[AW-1:0]];

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i && !empty_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q[AW-1:0]] <= data_i;
    end
  end

endmodule

/* rtl/spi_axil_regs.sv */
// AXI4-lite slave, one write and one read outstanding, no bursts
// Partial strobes only zero the masked bytes; TX writes stall while no credit is left
`timescale 1ns/1ps
module spi_axil_regs (
  input  logic                      clk_i,
  input  logic                      arst_i,
  input  logic                      s_awvalid_i,
  input  logic [31:0]               s_awaddr_i,
  output logic                      s_awready_o,
  input  logic                      s_wvalid_i,
  input  logic [31:0]               s_wdata_i,
  input  logic [3:0]                s_wstrb_i,
  output logic                      s_wready_o,
  output logic                      s_bvalid_o,
  output spi_pkg::spi_resp_e        s_bresp_o,
  input  logic                      s_bready_i,
  input  logic                      s_arvalid_i,
  input  logic [31:0]               s_araddr_i,
  output logic                      s_arready_o,
  output logic                      s_rvalid_o,
  output logic [31:0]               s_rdata_o,
  output spi_pkg::spi_resp_e        s_rresp_o,
  input  logic                      s_rready_i,
  output logic                      tx_push_o,
  output logic [7:0]                tx_data_o,
  input  logic                      tx_pop_i,
  input  logic [7:0]                rx_data_i,
  input  logic                      rx_empty_i,
  output logic                      rx_pop_o,
  output logic                      cpol_o,
  output logic                      cpha_o,
  output logic [3:0]                clk_div_o,
  output logic [spi_pkg::N_SLAVES-1:0] cs_n_o,
  output logic [spi_pkg::N_GPIO-1:0]   gpio_o
);
  import spi_pkg::*;

  logic [31:0]       wr_off;
  logic [31:0]       rd_off;
  logic [31:0]       wdata_m;
  logic [31:0]       rdata_d;
  logic [31:0]       rdata_q;
  spi_reg_e          wr_idx;
  spi_reg_e          wr_idx_q;
  spi_reg_e          rd_idx;
  logic              wr_legal;
  logic              wr_ok_q;
  logic              wr_tx;
  logic              rd_ok;
  logic              aw_done_q;
  logic              bvalid_q;
  logic              rvalid_q;
  spi_resp_e         bresp_q;
  spi_resp_e         rresp_d;
  spi_resp_e         rresp_q;
  logic              aw_hs;
  logic              w_hs;
  logic              ar_hs;
  logic [CFG_W-1:0]  cfg_q;
  logic [CFG_W-1:0]  cfg_wr;
  logic [N_GPIO-1:0] gpio_q;
  logic [CRED_W-1:0] tx_cred_q;

  // Write address decode, offsets below the base wrap and fall out of range
  assign wr_off   = s_awaddr_i - BASE_ADDR;
  assign wr_idx   = spi_reg_e'(wr_off[4:2]);
  assign wr_legal = (wr_off[31:2] <= 30'(REG_RX)) &&
                    (wr_idx == REG_CFG || wr_idx == REG_GPIO || wr_idx == REG_TX);

  assign s_awready_o = ~aw_done_q && ~bvalid_q;
  assign aw_hs       = s_awvalid_i && s_awready_o;

  assign wr_tx      = wr_ok_q && (wr_idx_q == REG_TX);
  assign s_wready_o = aw_done_q && (~wr_tx || (tx_cred_q != '0));  // TX credit back-pressure
  assign w_hs       = s_wvalid_i && s_wready_o;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wdata_m[8*i +: 8] = s_wstrb_i[i] ? s_wdata_i[8*i +: 8] : 8'h00;
    end
  end

  assign cfg_wr    = wdata_m[CFG_W-1:0] | CFG_W'(1 << CFG_DIV_LSB);  // Divider stays odd
  assign tx_push_o = w_hs && wr_tx;
  assign tx_data_o = wdata_m[7:0];

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;

  // Read decode and data select
  assign rd_off      = s_araddr_i - BASE_ADDR;
  assign rd_idx      = spi_reg_e'(rd_off[4:2]);
  assign rd_ok       = (rd_off[31:2] <= 30'(REG_RX)) && (rd_idx != REG_TX);
  assign s_arready_o = ~rvalid_q;
  assign ar_hs       = s_arvalid_i && s_arready_o;
  assign rx_pop_o    = ar_hs && rd_ok && (rd_idx == REG_RX) && ~rx_empty_i;

  always_comb begin
    rdata_d = '0;
    rresp_d = rd_ok ? RESP_OKAY : RESP_SLVERR;
    if (rd_ok) begin
      case (rd_idx)
        REG_CFG:     rdata_d = 32'(cfg_q);
        REG_GPIO:    rdata_d = 32'(gpio_q);
        REG_VERSION: rdata_d = VERSION_WORD;
        REG_RX:      rdata_d = rx_empty_i ? '0 : 32'(rx_data_i);  // Empty reads as zero
        default:     rdata_d = '0;
      endcase
    end
  end

  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = rresp_q;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      aw_done_q <= 1'b0;
      wr_idx_q  <= REG_CFG;
      wr_ok_q   <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= RESP_OKAY;
      rvalid_q  <= 1'b0;
      cfg_q     <= CFG_RESET;
      gpio_q    <= '0;
      tx_cred_q <= CRED_W'(TX_DEPTH);
    end else begin
      if (aw_hs) begin
        aw_done_q <= 1'b1;
        wr_idx_q  <= wr_idx;
        wr_ok_q   <= wr_legal;
      end else if (w_hs) begin
        aw_done_q <= 1'b0;
      end
      if (w_hs) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_ok_q ? RESP_OKAY : RESP_SLVERR;
        if (wr_ok_q && wr_idx_q == REG_CFG) cfg_q <= cfg_wr;
        if (wr_ok_q && wr_idx_q == REG_GPIO) gpio_q <= wdata_m[N_GPIO-1:0];
      end else if (bvalid_q && s_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rvalid_q && s_rready_i) begin
        rvalid_q <= 1'b0;
      end else if (ar_hs) begin
        rvalid_q <= 1'b1;
      end
      tx_cred_q <= tx_cred_q - CRED_W'(tx_push_o) + CRED_W'(tx_pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= rdata_d;
      rresp_q <= rresp_d;
    end
  end

  assign cpol_o    = cfg_q[0];
  assign cpha_o    = cfg_q[1];
  assign clk_div_o = cfg_q[CFG_DIV_LSB +: 4];
  assign cs_n_o    = ~cfg_q[CFG_SS_LSB +: N_SLAVES];
  assign gpio_o    = gpio_q;

endmodule

/* rtl/spi_shift_engine.sv */
// SPI byte shifter, MSB first, all four CPOL/CPHA modes, SCK from a clk divider
// Mode and divider must stay stable while a byte is on the wire
`timescale 1ns/1ps
module spi_shift_engine (
  input  logic       clk_i,
  input  logic       arst_i,
  input  logic       cpol_i,
  input  logic       cpha_i,
  input  logic [3:0] clk_div_i,
  input  logic [7:0] tx_data_i,
  input  logic       tx_empty_i,
  output logic       tx_pop_o,
  output logic       rx_push_o,
  output logic [7:0] rx_data_o,
  input  logic       rx_pop_i,
  output logic       sck_o,
  output logic       mosi_o,
  input  logic       miso_i
);
  import spi_pkg::*;

  spi_state_e        state_q;
  spi_state_e        state_d;
  logic [3:0]        div_cnt_q;
  logic [3:0]        half_cnt_q;  // SCK half period within the byte
  logic [GAP_W-1:0]  gap_cnt_q;
  logic [CRED_W-1:0] rx_cred_q;
  logic [7:0]        tx_sr_q;
  logic [7:0]        rx_sr_q;
  logic              sck_q;
  logic              mosi_q;
  logic              done_q;
  logic              tick;
  logic              last_edge;
  logic              capture;
  logic              launch;
  logic              can_start;
  logic              start;

  assign tick      = (state_q == SHIFT) && (div_cnt_q == clk_div_i);
  assign last_edge = tick && (half_cnt_q == 4'd15);
  // Even half periods end on odd edges, capture there when CPHA is 0
  assign capture   = tick && (half_cnt_q[0] == cpha_i);
  assign launch    = tick && (half_cnt_q[0] != cpha_i);
  assign can_start = ~tx_empty_i && (rx_cred_q != '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (can_start) state_d = SHIFT;
      end
      SHIFT: begin
        if (last_edge) state_d = GAP;
      end
      GAP: begin
        if (gap_cnt_q == GAP_W'(GAP_CYCLES - 1)) state_d = can_start ? SHIFT : IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  assign start = (state_q != SHIFT) && (state_d == SHIFT);

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q    <= IDLE;
      div_cnt_q  <= '0;
      half_cnt_q <= '0;
      gap_cnt_q  <= '0;
      rx_cred_q  <= CRED_W'(RX_DEPTH);
      sck_q      <= 1'b0;
      mosi_q     <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      done_q    <= last_edge;  // Byte complete, pop and push next cycle
      rx_cred_q <= rx_cred_q - CRED_W'(done_q) + CRED_W'(rx_pop_i);
      div_cnt_q <= (state_q == SHIFT && !tick) ? div_cnt_q + 4'd1 : 4'd0;
      gap_cnt_q <= (state_q == GAP) ? gap_cnt_q + GAP_W'(1) : '0;
      if (start) begin
        half_cnt_q <= '0;
      end else if (tick) begin
        half_cnt_q <= half_cnt_q + 4'd1;
      end
      if (state_q != SHIFT) begin
        sck_q <= cpol_i;  // Idle level
      end else if (tick) begin
        sck_q <= ~sck_q;
      end
      if (start) begin
        mosi_q <= tx_data_i[7];
      end else if (launch) begin
        mosi_q <= tx_sr_q[7];
      end
    end
  end

  // With CPHA 0 bit 7 is already on MOSI before the first edge
  always_ff @(posedge clk_i) begin
    if (start) begin
      tx_sr_q <= cpha_i ? tx_data_i : {tx_data_i[6:0], 1'b0};
    end else if (launch) begin
      tx_sr_q <= {tx_sr_q[6:0], 1'b0};
    end
    if (capture) begin
      rx_sr_q <= {rx_sr_q[6:0], miso_i};
    end
  end

  assign tx_pop_o  = done_q;
  assign rx_push_o = done_q;
  assign rx_data_o = rx_sr_q;
  assign sck_o     = sck_q;
  assign mosi_o    = mosi_q;

endmodule

/* rtl/spi_master_top.sv */
// Memory-mapped SPI master, single clock domain
// Register block sits at spi_pkg::BASE_ADDR, five word registers
`timescale 1ns/1ps
module spi_master_top (
  input  logic                         clk,
  input  logic                         arst,
  input  logic                         s_awvalid_i,
  input  logic [31:0]                  s_awaddr_i,
  output logic                         s_awready_o,
  input  logic                         s_wvalid_i,
  input  logic [31:0]                  s_wdata_i,
  input  logic [3:0]                   s_wstrb_i,
  output logic                         s_wready_o,
  output logic                         s_bvalid_o,
  output spi_pkg::spi_resp_e           s_bresp_o,
  input  logic                         s_bready_i,
  input  logic                         s_arvalid_i,
  input  logic [31:0]                  s_araddr_i,
  output logic                         s_arready_o,
  output logic                         s_rvalid_o,
  output logic [31:0]                  s_rdata_o,
  output spi_pkg::spi_resp_e           s_rresp_o,
  input  logic                         s_rready_i,
  output logic                         sck_o,
  output logic                         mosi_o,
  input  logic                         miso_i,
  output logic [spi_pkg::N_SLAVES-1:0] cs_n_o,
  output logic [spi_pkg::N_GPIO-1:0]   gpio_o
);
  import spi_pkg::*;

  logic       tx_push;
  logic [7:0] tx_wdata;
  logic       tx_pop;
  logic [7:0] tx_rdata;
  logic       tx_empty;
  logic       rx_push;
  logic [7:0] rx_wdata;
  logic       rx_pop;
  logic [7:0] rx_rdata;
  logic       rx_empty;
  logic       cpol;
  logic       cpha;
  logic [3:0] clk_div;

  spi_axil_regs u_regs (
    .clk_i       (clk),
    .arst_i      (arst),
    .s_awvalid_i (s_awvalid_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awready_o (s_awready_o),
    .s_wvalid_i  (s_wvalid_i),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wready_o  (s_wready_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bresp_o   (s_bresp_o),
    .s_bready_i  (s_bready_i),
    .s_arvalid_i (s_arvalid_i),
    .s_araddr_i  (s_araddr_i),
    .s_arready_o (s_arready_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rready_i  (s_rready_i),
    .tx_push_o   (tx_push),
    .tx_data_o   (tx_wdata),
    .tx_pop_i    (tx_pop),
    .rx_data_i   (rx_rdata),
    .rx_empty_i  (rx_empty),
    .rx_pop_o    (rx_pop),
    .cpol_o      (cpol),
    .cpha_o      (cpha),
    .clk_div_o   (clk_div),
    .cs_n_o      (cs_n_o),
    .gpio_o      (gpio_o)
  );

  spi_byte_fifo #(.DEPTH(TX_DEPTH)) u_tx_fifo (
    .clk_i   (clk),
    .arst_i  (arst),
    .push_i  (tx_push),
    .data_i  (tx_wdata),
    .pop_i   (tx_pop),
    .data_o  (tx_rdata),
    .empty_o (tx_empty)
  );

  spi_shift_engine u_engine (
    .clk_i      (clk),
    .arst_i     (arst),
    .cpol_i     (cpol),
    .cpha_i     (cpha),
    .clk_div_i  (clk_div),
    .tx_data_i  (tx_rdata),
    .tx_empty_i (tx_empty),
    .tx_pop_o   (tx_pop),
    .rx_push_o  (rx_push),
    .rx_data_o  (rx_wdata),
    .rx_pop_i   (rx_pop),
    .sck_o      (sck_o),
    .mosi_o     (mosi_o),
    .miso_i     (miso_i)
  );

  spi_byte_fifo #(.DEPTH(RX_DEPTH)) u_rx_fifo (
    .clk_i   (clk),
    .arst_i  (arst),
    .push_i  (rx_push),
    .data_i  (rx_wdata),
    .pop_i   (rx_pop),
    .data_o  (rx_rdata),
    .empty_o (rx_empty)
  );

endmodule

/* verification/spi_slave_model.sv */
// Behavioural SPI slave, counts bits only while cs_n_i is low
// Call restart after a mode change, a stray SCK idle-level step is then forgotten
`timescale 1ns/1ps
module spi_slave_model (
  input  logic cpol_i,
  input  logic cpha_i,
  input  logic cs_n_i,
  input  logic sck_i,
  input  logic mosi_i,
  output logic miso_o
);
  logic [7:0] reply_mem [32];
  logic [9:0] log_mem [32];  // Mode in bits 9:8, byte below
  logic [7:0] rx_sr;
  int         reply_idx;
  int         log_cnt;
  int         bit_cnt;

  initial begin
    miso_o    = 1'b0;
    rx_sr     = 8'h00;
    reply_idx = 0;
    log_cnt   = 0;
    bit_cnt   = 0;
  end

  task automatic set_reply(input int idx, input logic [7:0] b);
    reply_mem[idx] = b;
  endtask

  task automatic restart();
    reply_idx = 0;
    log_cnt   = 0;
    bit_cnt   = 0;
    miso_o    = reply_mem[0][7];  // CPHA 0 samples before any launch edge
  endtask

  function automatic logic [9:0] logged(input int idx);
    return log_mem[idx];
  endfunction

  // Capture on the rising edge when CPOL equals CPHA, else on the falling edge
  always @(sck_i) begin
    if (cs_n_i === 1'b0) begin
      if (sck_i === ~(cpol_i ^ cpha_i)) begin
        rx_sr = {rx_sr[6:0], mosi_i};
        bit_cnt++;
        if (bit_cnt == 8) begin
          log_mem[log_cnt] = {cpol_i, cpha_i, rx_sr};
          log_cnt++;
          reply_idx++;
          bit_cnt = 0;
        end
      end else begin
        miso_o = reply_mem[reply_idx][7 - bit_cnt];  // Next byte's MSB after edge 16
      end
    end
  end

endmodule

/* verification/tb_spi_master.sv */
// Testbench for the SPI master, register access, byte exchange in all modes, flow control
// Stops at the first error; random stimulus from a fixed seed
`timescale 1ns/1ps
module tb_spi_master;
  import spi_pkg::*;

  localparam int N_EXCH    = 4;  // Bytes per mode
  localparam int N_FLOW    = TX_DEPTH + RX_DEPTH + 2;
  localparam int BYTE_CYC  = 16 * 16 + GAP_CYCLES + 40;  // Slowest divider plus bus overhead
  localparam int LIMIT_CYC = (4 * N_EXCH + N_FLOW + 2) * BYTE_CYC + 2000;

  logic                clk;
  logic                arst;
  logic                awvalid;
  logic [31:0]         awaddr;
  logic                awready;
  logic                wvalid;
  logic [31:0]         wdata;
  logic [3:0]          wstrb;
  logic                wready;
  logic                bvalid;
  spi_resp_e           bresp;
  logic                bready;
  logic                arvalid;
  logic [31:0]         araddr;
  logic                arready;
  logic                rvalid;
  logic [31:0]         rdata;
  spi_resp_e           rresp;
  logic                rready;
  logic                sck;
  logic                mosi;
  logic                miso;
  logic [N_SLAVES-1:0] cs_n;
  logic [N_GPIO-1:0]   gpio;
  logic [CFG_W-1:0]    cfg_m;  // Reference model registers
  logic [N_GPIO-1:0]   gpio_m;
  logic [7:0]          sent_q [$];
  logic [7:0]          reply_q [$];
  int                  push_cnt;
  string               test_name;

  spi_master_top u_dut (
    .clk (clk), .arst (arst),
    .s_awvalid_i (awvalid), .s_awaddr_i (awaddr), .s_awready_o (awready),
    .s_wvalid_i (wvalid), .s_wdata_i (wdata), .s_wstrb_i (wstrb), .s_wready_o (wready),
    .s_bvalid_o (bvalid), .s_bresp_o (bresp), .s_bready_i (bready),
    .s_arvalid_i (arvalid), .s_araddr_i (araddr), .s_arready_o (arready),
    .s_rvalid_o (rvalid), .s_rdata_o (rdata), .s_rresp_o (rresp), .s_rready_i (rready),
    .sck_o (sck), .mosi_o (mosi), .miso_i (miso), .cs_n_o (cs_n), .gpio_o (gpio)
  );

  spi_slave_model u_slave (
    .cpol_i (cfg_m[0]), .cpha_i (cfg_m[1]), .cs_n_i (cs_n[0]),
    .sck_i (sck), .mosi_i (mosi), .miso_o (miso)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (u_dut.rx_push === 1'b1) push_cnt = push_cnt + 1;  // One per finished byte
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at the first error");
  endtask

  initial begin
    repeat (LIMIT_CYC) @(posedge clk);
    abort_run($sformatf("Timeout, the run did not finish within %0d cycles", LIMIT_CYC));
  end

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
                          test_name, what, exp, act));
    end
  endtask

  function automatic logic [31:0] reg_addr(input int idx);
    return BASE_ADDR + 32'(idx) * 32'd4;
  endfunction

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           output spi_resp_e resp);
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = addr;
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    while (!wready) @(negedge clk);  // Low while TX credits are used up
    @(negedge clk);
    wvalid = 1'b0;
    bready = 1'b1;
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                          output spi_resp_e resp);
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    rready  = 1'b1;
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Selects slave 0 with a random divider
  task automatic set_mode(input logic pol, input logic pha);
    logic [31:0] v;
    spi_resp_e   resp;
    v = (32'd1 << CFG_SS_LSB) | (32'($urandom_range(0, 15)) << CFG_DIV_LSB) | {30'd0, pha, pol};
    write_reg(reg_addr(REG_CFG), v, resp);
    check_eq("mode write response", RESP_OKAY, resp);
    cfg_m = v[CFG_W-1:0];
    cfg_m[CFG_DIV_LSB] = 1'b1;
    check_eq("cs_n with slave selected", 0, cs_n);
  endtask

  task automatic prepare_bytes(input int n);
    sent_q.delete();
    reply_q.delete();
    for (int i = 0; i < n; i++) begin
      sent_q.push_back(8'($urandom));
      reply_q.push_back(8'($urandom));
      u_slave.set_reply(i, reply_q[i]);
    end
    u_slave.restart();
  endtask

  task automatic send_bytes();
    spi_resp_e resp;
    foreach (sent_q[i]) begin
      write_reg(reg_addr(REG_TX), 32'(sent_q[i]), resp);
      check_eq("TX write response", RESP_OKAY, resp);
    end
  endtask

  // Waits for byte i of this batch to be pushed, then reads it back
  task automatic read_rx_checked(input int base, input int i);
    logic [31:0] rd;
    spi_resp_e   resp;
    wait (push_cnt > base + i);
    read_reg(reg_addr(REG_RX), rd, resp);
    check_eq($sformatf("RX byte %0d", i), 32'(reply_q[i]), rd);
    check_eq("RX read response", RESP_OKAY, resp);
  endtask

  task automatic check_log(input int n);
    check_eq("slave byte count", n, u_slave.log_cnt);
    for (int i = 0; i < n; i++) begin
      check_eq($sformatf("slave log %0d", i), {22'd0, cfg_m[0], cfg_m[1], sent_q[i]},
               32'(u_slave.logged(i)));
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [31:0] rd;
    spi_resp_e   resp;
    int          base;
    void'($urandom(37));
    arst     = 1'b1;
    awvalid  = 1'b0;
    awaddr   = '0;
    wvalid   = 1'b0;
    wdata    = '0;
    wstrb    = 4'hf;
    bready   = 1'b0;
    arvalid  = 1'b0;
    araddr   = '0;
    rready   = 1'b0;
    push_cnt = 0;
    cfg_m    = CFG_RESET;
    gpio_m   = '0;
    repeat (3) @(negedge clk);
    arst = 1'b0;

    test_name = "reset and version";
    check_eq("awready", 1, awready);
    check_eq("arready", 1, arready);
    check_eq("wready", 0, wready);
    check_eq("bvalid", 0, bvalid);
    check_eq("rvalid", 0, rvalid);
    check_eq("cs_n", {N_SLAVES{1'b1}}, cs_n);
    check_eq("sck", 0, sck);
    check_eq("mosi", 0, mosi);
    check_eq("gpio", 0, gpio);
    read_reg(reg_addr(REG_VERSION), rd, resp);
    check_eq("version", VERSION_WORD, rd);
    check_eq("version response", RESP_OKAY, resp);

    test_name = "register write/read";
    for (int i = 0; i < 4; i++) begin
      v = $urandom;
      write_reg(reg_addr(REG_CFG), v, resp);
      check_eq("CFG write response", RESP_OKAY, resp);
      cfg_m = v[CFG_W-1:0];
      cfg_m[CFG_DIV_LSB] = 1'b1;  // Divider bit 0 reads as 1
      v = $urandom;
      write_reg(reg_addr(REG_GPIO), v, resp);
      check_eq("GPIO write response", RESP_OKAY, resp);
      gpio_m = v[N_GPIO-1:0];
      read_reg(reg_addr(REG_CFG), rd, resp);
      check_eq("CFG readback", 32'(cfg_m), rd);
      read_reg(reg_addr(REG_GPIO), rd, resp);
      check_eq("GPIO readback", 32'(gpio_m), rd);
      check_eq("gpio pins", 32'(gpio_m), gpio);
      check_eq("cs_n pins", N_SLAVES'(~cfg_m[CFG_SS_LSB +: N_SLAVES]), cs_n);
    end

    test_name = "access errors";
    write_reg(reg_addr(REG_VERSION), $urandom, resp);
    check_eq("VERSION write response", RESP_SLVERR, resp);
    write_reg(reg_addr(REG_RX), $urandom, resp);
    check_eq("RX write response", RESP_SLVERR, resp);
    write_reg(reg_addr(5 + $urandom_range(0, 10)), $urandom, resp);
    check_eq("out of range write response", RESP_SLVERR, resp);
    read_reg(reg_addr(REG_TX), rd, resp);
    check_eq("TX read response", RESP_SLVERR, resp);
    check_eq("TX read data", 0, rd);
    read_reg(reg_addr(5 + $urandom_range(0, 10)), rd, resp);
    check_eq("out of range read response", RESP_SLVERR, resp);
    check_eq("out of range read data", 0, rd);
    read_reg(reg_addr(REG_CFG), rd, resp);
    check_eq("CFG unchanged", 32'(cfg_m), rd);
    read_reg(reg_addr(REG_GPIO), rd, resp);
    check_eq("GPIO unchanged", 32'(gpio_m), rd);
    read_reg(reg_addr(REG_VERSION), rd, resp);
    check_eq("version unchanged", VERSION_WORD, rd);

    test_name = "byte exchange";
    for (int m = 0; m < 4; m++) begin
      set_mode(m[1], m[0]);
      prepare_bytes(N_EXCH);
      base = push_cnt;
      send_bytes();
      for (int i = 0; i < N_EXCH; i++) read_rx_checked(base, i);
      check_log(N_EXCH);
    end

    test_name = "flow control";
    set_mode(1'($urandom), 1'($urandom));
    prepare_bytes(N_FLOW);
    base = push_cnt;
    fork
      send_bytes();
      begin
        wait (push_cnt == base + RX_DEPTH);
        repeat (2 * BYTE_CYC) @(negedge clk);  // RX full, engine must hold
        check_eq("bytes pushed while RX full", base + RX_DEPTH, push_cnt);
        for (int i = 0; i < N_FLOW; i++) read_rx_checked(base, i);
      end
    join
    check_log(N_FLOW);
    read_reg(reg_addr(REG_RX), rd, resp);
    check_eq("empty RX data", 0, rd);
    check_eq("empty RX response", RESP_OKAY, resp);

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* compile.f */
rtl/spi_pkg.sv
rtl/spi_byte_fifo.sv
rtl/spi_axil_regs.sv
rtl/spi_shift_engine.sv
rtl/spi_master_top.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

/* Bender.yml */
package:
  name: spi_master

sources:
  - files:
      - rtl/spi_pkg.sv
      - rtl/spi_byte_fifo.sv
      - rtl/spi_axil_regs.sv
      - rtl/spi_shift_engine.sv
      - rtl/spi_master_top.sv
  - target: simulation
    files:
      - verification/spi_slave_model.sv
      - verification/tb_spi_master.sv
